// ==== logic/dds_pkg.sv ====
package dds_pkg;

    // signal path
    localparam int SAMPLE_W = 8;
    localparam int PHASE_W = 32;

    // default waveform table depth is 2**TABLE_AW
    localparam int TABLE_AW = 8;

    // fraction bits of every gain, 256 is unity
    localparam int GAIN_RADIX = 8;

    // scaled modulation words, gains use the same width
    localparam int MOD_W = 16;

    // source codes shared by the output selector and the modulation selectors
    // src_dds only means something to the output selector
    typedef enum logic [1:0] {
        src_raw = 2'd0,
        src_ina = 2'd1,
        src_inb = 2'd2,
        src_dds = 2'd3
    } src_sel_t;

endpackage

// ==== logic/dds_regs_pkg.sv ====
package dds_regs_pkg;

    // byte addresses, one 32-bit register each
    localparam logic [31:0] ADDR_OUT_SEL = 32'h00;
    localparam logic [31:0] ADDR_RAW = 32'h04;
    localparam logic [31:0] ADDR_STEP = 32'h08;
    localparam logic [31:0] ADDR_TABLE = 32'h0C;
    localparam logic [31:0] ADDR_NOISE = 32'h10;

    localparam logic [31:0] ADDR_AM_SRC = 32'h14;
    localparam logic [31:0] ADDR_AM_RAW = 32'h18;
    localparam logic [31:0] ADDR_AM_GAIN = 32'h1C;
    localparam logic [31:0] ADDR_FM_SRC = 32'h20;
    localparam logic [31:0] ADDR_FM_RAW = 32'h24;
    localparam logic [31:0] ADDR_FM_GAIN = 32'h28;
    localparam logic [31:0] ADDR_PM_SRC = 32'h2C;
    localparam logic [31:0] ADDR_PM_RAW = 32'h30;
    localparam logic [31:0] ADDR_PM_GAIN = 32'h34;

    localparam logic [31:0] ADDR_STAT_CFG = 32'h40;
    localparam logic [31:0] ADDR_STAT_LIMIT = 32'h44;
    // read only
    localparam logic [31:0] ADDR_STAT_MIN = 32'h48;
    localparam logic [31:0] ADDR_STAT_MAX = 32'h4C;
    localparam logic [31:0] ADDR_STAT_COUNT = 32'h50;

    // table write word
    localparam int TABLE_DATA_LSB = 0;
    localparam int TABLE_ADDR_LSB = 8;

    // noise word
    localparam int NOISE_GAIN_LSB = 0;
    localparam int NOISE_OFFSET_LSB = 16;

    // statistics config bits
    localparam int STAT_CLEAR_BIT = 0;
    localparam int STAT_ENABLE_BIT = 1;

endpackage

// ==== logic/gain_offset_clamp.sv ====
module gain_offset_clamp
    import dds_pkg::*;
#(
    parameter int IN_W = 8,
    parameter int GAIN_W = 16,
    parameter int OUT_W = 8
) (
    input  logic                     clk,
    input  logic signed [IN_W-1:0]   din,
    input  logic signed [GAIN_W-1:0] gain,
    input  logic signed [OUT_W-1:0]  offset,
    output logic signed [OUT_W-1:0]  dout
);

    localparam int PROD_W = IN_W + GAIN_W;
    // one spare bit so the offset add cannot wrap
    localparam int SUM_W = PROD_W + 1;

    localparam logic signed [SUM_W-1:0] OUT_MAX = SUM_W'((2 ** (OUT_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] OUT_MIN = SUM_W'(-(2 ** (OUT_W - 1)));

    logic signed [PROD_W-1:0] product;
    logic signed [SUM_W-1:0]  shifted;
    logic signed [SUM_W-1:0]  sum;

    always_comb begin
        product = din * gain;
        // drop the gain fraction bits, keeping the sign
        shifted = SUM_W'(product >>> GAIN_RADIX);
        sum = shifted + SUM_W'(offset);
    end

    // saturate into the output range
    always_ff @(posedge clk) begin
        if (sum > OUT_MAX) begin
            dout <= OUT_MAX[OUT_W-1:0];
        end else if (sum < OUT_MIN) begin
            dout <= OUT_MIN[OUT_W-1:0];
        end else begin
            dout <= sum[OUT_W-1:0];
        end
    end

endmodule

// ==== logic/prbs.sv ====
module prbs
    import dds_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    output logic signed [SAMPLE_W-1:0] data
);

    // any nonzero start state works for a maximal-length sequence
    localparam logic [14:0] SEED = 15'h2d51;

    logic [14:0] lfsr;
    logic        feedback;

    // x^15 + x^14 + 1
    assign feedback = lfsr[14] ^ lfsr[13];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {lfsr[13:0], feedback};
        end
    end

    // low bits read as a signed noise sample
    assign data = lfsr[SAMPLE_W-1:0];

endmodule

// ==== logic/dds.sv ====
module dds
    import dds_pkg::*;
#(
    parameter int TABLE_AW = dds_pkg::TABLE_AW
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [PHASE_W-1:0]         step,
    input  logic signed [MOD_W-1:0]    fm,
    input  logic signed [MOD_W-1:0]    pm,

    input  logic [TABLE_AW-1:0]        table_addr,
    input  logic [SAMPLE_W-1:0]        table_data,
    input  logic                       table_we,

    output logic signed [SAMPLE_W-1:0] dout
);

    localparam int MOD_SHIFT = PHASE_W - MOD_W;

    logic [PHASE_W-1:0]  phase;
    logic [PHASE_W-1:0]  fm_step;
    logic [PHASE_W-1:0]  pm_phase;
    logic [PHASE_W-1:0]  read_phase;
    logic [TABLE_AW-1:0] read_addr;

    // waveform table, loaded by software
    logic [SAMPLE_W-1:0] wave_table [2**TABLE_AW];

    always_comb begin
        // modulation words sit at the top of the phase word
        fm_step = PHASE_W'(fm) << MOD_SHIFT;
        pm_phase = PHASE_W'(pm) << MOD_SHIFT;
        read_phase = phase + pm_phase;
        read_addr = read_phase[PHASE_W-1 -: TABLE_AW];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + step + fm_step;
        end
    end

    always_ff @(posedge clk) begin
        if (table_we) begin
            wave_table[table_addr] <= table_data;
        end
    end

    // registered read, one cycle behind the phase
    always_ff @(posedge clk) begin
        dout <= wave_table[read_addr];
    end

endmodule

// ==== logic/sigstat.sv ====
module sigstat #(
    parameter int WIDTH = 8
) (
    input  logic                    clk,
    input  logic                    clear,
    input  logic                    enable,
    input  logic signed [WIDTH-1:0] sig,
    input  logic [31:0]             limit,
    output logic signed [WIDTH-1:0] min,
    output logic signed [WIDTH-1:0] max,
    output logic [31:0]             count
);

    localparam logic signed [WIDTH-1:0] LARGEST = {1'b0, {(WIDTH - 1){1'b1}}};
    localparam logic signed [WIDTH-1:0] SMALLEST = {1'b1, {(WIDTH - 1){1'b0}}};

    logic window_open;

    assign window_open = enable && (count < limit);

    always_ff @(posedge clk) begin
        if (clear) begin
            // start inverted so the first sample sets both
            count <= '0;
            min <= LARGEST;
            max <= SMALLEST;
        end else if (window_open) begin
            count <= count + 32'd1;
            if (sig < min) begin
                min <= sig;
            end
            if (sig > max) begin
                max <= sig;
            end
        end
    end

    // results hold once count reaches limit

endmodule

// ==== logic/dds_regs.sv ====
module dds_regs
    import dds_pkg::*, dds_regs_pkg::*;
#(
    parameter int TABLE_AW = dds_pkg::TABLE_AW
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       psel,
    input  logic                       penable,
    input  logic [31:0]                paddr,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,

    output src_sel_t                   out_sel,
    output src_sel_t                   am_src,
    output src_sel_t                   fm_src,
    output src_sel_t                   pm_src,

    output logic signed [SAMPLE_W-1:0] raw,
    output logic signed [MOD_W-1:0]    am_raw,
    output logic signed [MOD_W-1:0]    fm_raw,
    output logic signed [MOD_W-1:0]    pm_raw,

    output logic signed [MOD_W-1:0]    am_gain,
    output logic signed [MOD_W-1:0]    fm_gain,
    output logic signed [MOD_W-1:0]    pm_gain,

    output logic [PHASE_W-1:0]         step,

    output logic [TABLE_AW-1:0]        table_addr,
    output logic [SAMPLE_W-1:0]        table_data,
    output logic                       table_we,

    output logic signed [MOD_W-1:0]    noise_gain,
    output logic signed [SAMPLE_W-1:0] noise_offset,

    output logic                       stat_clear,
    output logic                       stat_enable,
    output logic [31:0]                stat_limit,
    input  logic signed [SAMPLE_W-1:0] stat_min,
    input  logic signed [SAMPLE_W-1:0] stat_max,
    input  logic [31:0]                stat_count
);

    localparam logic signed [MOD_W-1:0] UNITY = MOD_W'(1 << GAIN_RADIX);

    logic wr_en;

    // APB access phase, no wait states
    assign wr_en = psel && penable && pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_sel <= src_raw;
            am_src <= src_raw;
            fm_src <= src_raw;
            pm_src <= src_raw;
            raw <= '0;
            // AM path starts at unity
            am_raw <= UNITY;
            am_gain <= UNITY;
            fm_raw <= '0;
            fm_gain <= '0;
            pm_raw <= '0;
            pm_gain <= '0;
            step <= '0;
            table_addr <= '0;
            table_data <= '0;
            table_we <= 1'b0;
            noise_gain <= '0;
            noise_offset <= '0;
            stat_clear <= 1'b0;
            stat_enable <= 1'b0;
            stat_limit <= '0;
        end else begin
            // strobes last one cycle
            table_we <= 1'b0;
            stat_clear <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    ADDR_OUT_SEL: out_sel <= src_sel_t'(pwdata[1:0]);
                    ADDR_RAW: raw <= pwdata[SAMPLE_W-1:0];
                    ADDR_STEP: step <= pwdata[PHASE_W-1:0];
                    ADDR_TABLE: begin
                        table_addr <= pwdata[TABLE_ADDR_LSB +: TABLE_AW];
                        table_data <= pwdata[TABLE_DATA_LSB +: SAMPLE_W];
                        table_we <= 1'b1;
                    end
                    ADDR_NOISE: begin
                        noise_gain <= pwdata[NOISE_GAIN_LSB +: MOD_W];
                        noise_offset <= pwdata[NOISE_OFFSET_LSB +: SAMPLE_W];
                    end
                    ADDR_AM_SRC: am_src <= src_sel_t'(pwdata[1:0]);
                    ADDR_AM_RAW: am_raw <= pwdata[MOD_W-1:0];
                    ADDR_AM_GAIN: am_gain <= pwdata[MOD_W-1:0];
                    ADDR_FM_SRC: fm_src <= src_sel_t'(pwdata[1:0]);
                    ADDR_FM_RAW: fm_raw <= pwdata[MOD_W-1:0];
                    ADDR_FM_GAIN: fm_gain <= pwdata[MOD_W-1:0];
                    ADDR_PM_SRC: pm_src <= src_sel_t'(pwdata[1:0]);
                    ADDR_PM_RAW: pm_raw <= pwdata[MOD_W-1:0];
                    ADDR_PM_GAIN: pm_gain <= pwdata[MOD_W-1:0];
                    ADDR_STAT_CFG: begin
                        stat_clear <= pwdata[STAT_CLEAR_BIT];
                        stat_enable <= pwdata[STAT_ENABLE_BIT];
                    end
                    ADDR_STAT_LIMIT: stat_limit <= pwdata;
                    default: ;
                endcase
            end
        end
    end

    // readback zero-extends each field
    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                ADDR_OUT_SEL: prdata[1:0] = out_sel;
                ADDR_RAW: prdata[SAMPLE_W-1:0] = raw;
                ADDR_STEP: prdata[PHASE_W-1:0] = step;
                ADDR_TABLE: begin
                    prdata[TABLE_ADDR_LSB +: TABLE_AW] = table_addr;
                    prdata[TABLE_DATA_LSB +: SAMPLE_W] = table_data;
                end
                ADDR_NOISE: begin
                    prdata[NOISE_GAIN_LSB +: MOD_W] = noise_gain;
                    prdata[NOISE_OFFSET_LSB +: SAMPLE_W] = noise_offset;
                end
                ADDR_AM_SRC: prdata[1:0] = am_src;
                ADDR_AM_RAW: prdata[MOD_W-1:0] = am_raw;
                ADDR_AM_GAIN: prdata[MOD_W-1:0] = am_gain;
                ADDR_FM_SRC: prdata[1:0] = fm_src;
                ADDR_FM_RAW: prdata[MOD_W-1:0] = fm_raw;
                ADDR_FM_GAIN: prdata[MOD_W-1:0] = fm_gain;
                ADDR_PM_SRC: prdata[1:0] = pm_src;
                ADDR_PM_RAW: prdata[MOD_W-1:0] = pm_raw;
                ADDR_PM_GAIN: prdata[MOD_W-1:0] = pm_gain;
                // clear is a pulse, only enable reads back
                ADDR_STAT_CFG: prdata[STAT_ENABLE_BIT] = stat_enable;
                ADDR_STAT_LIMIT: prdata = stat_limit;
                ADDR_STAT_MIN: prdata[SAMPLE_W-1:0] = stat_min;
                ADDR_STAT_MAX: prdata[SAMPLE_W-1:0] = stat_max;
                ADDR_STAT_COUNT: prdata = stat_count;
                default: prdata = '0;
            endcase
        end
    end

endmodule

// ==== logic/dds_block.sv ====
module dds_block
    import dds_pkg::*;
#(
    parameter int TABLE_AW = dds_pkg::TABLE_AW
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       psel,
    input  logic                       penable,
    input  logic [31:0]                paddr,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,

    input  logic signed [SAMPLE_W-1:0] ina,
    input  logic signed [SAMPLE_W-1:0] inb,
    output logic signed [SAMPLE_W-1:0] dds_out
);

    src_sel_t out_sel;
    src_sel_t am_src;
    src_sel_t fm_src;
    src_sel_t pm_src;

    logic signed [SAMPLE_W-1:0] raw;
    logic signed [MOD_W-1:0]    am_raw;
    logic signed [MOD_W-1:0]    fm_raw;
    logic signed [MOD_W-1:0]    pm_raw;
    logic signed [MOD_W-1:0]    am_gain;
    logic signed [MOD_W-1:0]    fm_gain;
    logic signed [MOD_W-1:0]    pm_gain;
    logic [PHASE_W-1:0]         step;

    logic [TABLE_AW-1:0]        table_addr;
    logic [SAMPLE_W-1:0]        table_data;
    logic                       table_we;

    logic signed [MOD_W-1:0]    noise_gain;
    logic signed [SAMPLE_W-1:0] noise_offset;
    logic signed [SAMPLE_W-1:0] prbs_data;
    logic signed [SAMPLE_W-1:0] noise_scaled;

    logic                       stat_clear;
    logic                       stat_enable;
    logic [31:0]                stat_limit;
    logic signed [SAMPLE_W-1:0] stat_min;
    logic signed [SAMPLE_W-1:0] stat_max;
    logic [31:0]                stat_count;

    logic signed [MOD_W-1:0]    am_scaled;
    logic signed [MOD_W-1:0]    fm_scaled;
    logic signed [MOD_W-1:0]    pm_scaled;
    logic signed [SAMPLE_W-1:0] dds_sample;
    logic signed [SAMPLE_W-1:0] src_sample;
    logic signed [SAMPLE_W:0]   noisy;
    logic signed [SAMPLE_W-1:0] noisy_sat;

    // modulation source; src_dds is not a modulation source and falls back to raw
    function automatic logic signed [MOD_W-1:0] mod_pick(
        input src_sel_t                   sel,
        input logic signed [MOD_W-1:0]    raw_val,
        input logic signed [SAMPLE_W-1:0] a,
        input logic signed [SAMPLE_W-1:0] b
    );
        case (sel)
            src_ina: mod_pick = MOD_W'(a);
            src_inb: mod_pick = MOD_W'(b);
            default: mod_pick = raw_val;
        endcase
    endfunction

    dds_regs #(.TABLE_AW(TABLE_AW)) regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .paddr(paddr),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .out_sel(out_sel), .am_src(am_src), .fm_src(fm_src), .pm_src(pm_src),
        .raw(raw), .am_raw(am_raw), .fm_raw(fm_raw), .pm_raw(pm_raw),
        .am_gain(am_gain), .fm_gain(fm_gain), .pm_gain(pm_gain),
        .step(step),
        .table_addr(table_addr), .table_data(table_data), .table_we(table_we),
        .noise_gain(noise_gain), .noise_offset(noise_offset),
        .stat_clear(stat_clear), .stat_enable(stat_enable), .stat_limit(stat_limit),
        .stat_min(stat_min), .stat_max(stat_max), .stat_count(stat_count)
    );

    gain_offset_clamp #(.IN_W(MOD_W), .GAIN_W(MOD_W), .OUT_W(MOD_W)) am_scale (
        .clk(clk), .din(mod_pick(am_src, am_raw, ina, inb)),
        .gain(am_gain), .offset('0), .dout(am_scaled)
    );

    gain_offset_clamp #(.IN_W(MOD_W), .GAIN_W(MOD_W), .OUT_W(MOD_W)) fm_scale (
        .clk(clk), .din(mod_pick(fm_src, fm_raw, ina, inb)),
        .gain(fm_gain), .offset('0), .dout(fm_scaled)
    );

    gain_offset_clamp #(.IN_W(MOD_W), .GAIN_W(MOD_W), .OUT_W(MOD_W)) pm_scale (
        .clk(clk), .din(mod_pick(pm_src, pm_raw, ina, inb)),
        .gain(pm_gain), .offset('0), .dout(pm_scaled)
    );

    dds #(.TABLE_AW(TABLE_AW)) dds_inst (
        .clk(clk), .rst(rst), .step(step), .fm(fm_scaled), .pm(pm_scaled),
        .table_addr(table_addr), .table_data(table_data), .table_we(table_we),
        .dout(dds_sample)
    );

    prbs prbs_inst (.clk(clk), .rst(rst), .data(prbs_data));

    gain_offset_clamp #(.IN_W(SAMPLE_W), .GAIN_W(MOD_W), .OUT_W(SAMPLE_W)) noise_scale (
        .clk(clk), .din(prbs_data), .gain(noise_gain),
        .offset(noise_offset), .dout(noise_scaled)
    );

    always_comb begin
        case (out_sel)
            src_raw: src_sample = raw;
            src_ina: src_sample = ina;
            src_inb: src_sample = inb;
            default: src_sample = dds_sample;
        endcase
        noisy = (SAMPLE_W + 1)'(src_sample) + (SAMPLE_W + 1)'(noise_scaled);
    end

    // clamp on overflow of the noise sum, then register it
    always_ff @(posedge clk) begin
        if (rst) begin
            noisy_sat <= '0;
        end else if (noisy[SAMPLE_W] != noisy[SAMPLE_W-1]) begin
            noisy_sat <= {noisy[SAMPLE_W], {(SAMPLE_W - 1){~noisy[SAMPLE_W]}}};
        end else begin
            noisy_sat <= noisy[SAMPLE_W-1:0];
        end
    end

    gain_offset_clamp #(.IN_W(SAMPLE_W), .GAIN_W(MOD_W), .OUT_W(SAMPLE_W)) am_stage (
        .clk(clk), .din(noisy_sat), .gain(am_scaled), .offset('0), .dout(dds_out)
    );

    // reset also clears the statistics so they start defined
    sigstat #(.WIDTH(SAMPLE_W)) sigstat_inst (
        .clk(clk), .clear(stat_clear || rst), .enable(stat_enable),
        .sig(dds_out), .limit(stat_limit),
        .min(stat_min), .max(stat_max), .count(stat_count)
    );

endmodule

// ==== tests/dds_block_assertions.sv ====
module dds_block_assertions
    import dds_pkg::*;
(
    input logic                       clk,
    input logic                       rst,
    input logic signed [SAMPLE_W-1:0] dds_out,
    input logic signed [SAMPLE_W-1:0] stat_min,
    input logic signed [SAMPLE_W-1:0] stat_max,
    input logic [31:0]                stat_count,
    input logic [31:0]                stat_limit
);

    int failures = 0;

    // min and max only mean something once a sample was taken
    property min_not_above_max;
        @(posedge clk) disable iff (rst) (stat_count != 0) |-> (stat_min <= stat_max);
    endproperty

    property count_within_limit;
        @(posedge clk) disable iff (rst) stat_count <= stat_limit;
    endproperty

    property output_known;
        @(posedge clk) disable iff (rst) !$isunknown(dds_out);
    endproperty

    min_max_order: assert property (min_not_above_max)
        else begin
            $error("statistics minimum is above the maximum");
            failures++;
        end
    count_limit: assert property (count_within_limit)
        else begin
            $error("statistics count is above the window limit");
            failures++;
        end
    out_known: assert property (output_known)
        else begin
            $error("dds_out is unknown");
            failures++;
        end

endmodule

// ==== tests/dds_block_tb.sv ====
module dds_block_tb
    import dds_pkg::*, dds_regs_pkg::*;
();

    // about ten times the length of the whole sequence
    localparam int MAX_CYCLES = 20000;
    localparam int SETTLE = 16;
    localparam int UNITY = 1 << GAIN_RADIX;
    // one table entry per clock
    localparam logic [31:0] STEP_ONE = 32'd1 << (PHASE_W - TABLE_AW);
    localparam logic [31:0] STAT_START = (1 << STAT_CLEAR_BIT) | (1 << STAT_ENABLE_BIT);

    localparam logic [31:0] RW_ADDR [16] = '{
        ADDR_OUT_SEL, ADDR_RAW, ADDR_STEP, ADDR_TABLE, ADDR_NOISE,
        ADDR_AM_SRC, ADDR_AM_RAW, ADDR_AM_GAIN, ADDR_FM_SRC, ADDR_FM_RAW, ADDR_FM_GAIN,
        ADDR_PM_SRC, ADDR_PM_RAW, ADDR_PM_GAIN, ADDR_STAT_CFG, ADDR_STAT_LIMIT
    };
    // readable bits of each register above
    localparam logic [31:0] RW_MASK [16] = '{
        32'h3, 32'hff, 32'hffff_ffff, 32'hffff, 32'hff_ffff,
        32'h3, 32'hffff, 32'hffff, 32'h3, 32'hffff, 32'hffff,
        32'h3, 32'hffff, 32'hffff, 32'h2, 32'hffff_ffff
    };

    logic                       clk;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic [31:0]                paddr;
    logic                       pwrite;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic signed [SAMPLE_W-1:0] ina;
    logic signed [SAMPLE_W-1:0] inb;
    logic signed [SAMPLE_W-1:0] dds_out;

    logic [15:0] lfsr_state = 16'd51;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic        armed = 1'b0;
    int          expected_value = 0;

    dds_block #(.TABLE_AW(TABLE_AW)) UUT (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata),
        .ina(ina), .inb(inb), .dds_out(dds_out)
    );

    bind dds_block dds_block_assertions assertions_inst (
        .clk(clk), .rst(rst), .dds_out(dds_out),
        .stat_min(stat_min), .stat_max(stat_max),
        .stat_count(stat_count), .stat_limit(stat_limit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < width; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic int random_signed(input int width);
        logic [31:0] bits;
        bits = random_bits(width);
        if (bits[width-1]) begin
            return int'(bits) - (1 << width);
        end
        return int'(bits);
    endfunction

    function automatic int saturate(input longint value, input int width);
        longint hi;
        hi = (longint'(1) << (width - 1)) - 1;
        if (value > hi) begin
            return int'(hi);
        end
        if (value < -hi - 1) begin
            return int'(-hi - 1);
        end
        return int'(value);
    endfunction

    // multiply, drop the gain fraction, add offset, saturate
    function automatic int gain_clamp(input int din, input int gain, input int offset,
                                      input int width);
        return saturate(((longint'(din) * gain) >>> GAIN_RADIX) + offset, width);
    endfunction

    // saturating noise sum, then the AM stage with its own scaled gain
    function automatic int expected_out(input int src, input int noise, input int am_raw,
                                        input int am_gain);
        int am_scaled;
        am_scaled = gain_clamp(am_raw, am_gain, 0, MOD_W);
        return gain_clamp(saturate(src + noise, SAMPLE_W), am_scaled, 0, SAMPLE_W);
    endfunction

    task automatic check_equal(input logic signed [63:0] actual,
                               input logic signed [63:0] expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        data = prdata;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // arms the compare process for four samples
    task automatic expect_output(input int value);
        expected_value <= value;
        armed <= 1'b1;
        wait_cycles(4);
        armed <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (armed) begin
            check_equal(dds_out, expected_value, "dds_out against reference");
        end
    end

    // consecutive samples differ by stride modulo 256
    task automatic check_stride(input int n, input int stride, input string what);
        int prev;
        int cur;
        prev = dds_out;
        repeat (n) begin
            @(negedge clk);
            cur = dds_out;
            check_equal((cur - prev) & 255, stride, what);
            prev = cur;
        end
    endtask

    task automatic wait_stat_count(input int target);
        logic [31:0] count;
        int          polls;
        count = '0;
        polls = 0;
        while (count != target && polls < 100) begin
            apb_read(ADDR_STAT_COUNT, count);
            polls++;
        end
        if (count != target) begin
            errors++;
            $display("statistics count stayed at %0d and never reached %0d", count, target);
        end
    endtask

    task automatic restore_defaults();
        apb_write(ADDR_OUT_SEL, 32'(src_raw));
        apb_write(ADDR_STEP, 0);
        apb_write(ADDR_NOISE, 0);
        apb_write(ADDR_AM_SRC, 32'(src_raw));
        apb_write(ADDR_AM_RAW, UNITY);
        apb_write(ADDR_AM_GAIN, UNITY);
        apb_write(ADDR_FM_SRC, 32'(src_raw));
        apb_write(ADDR_FM_GAIN, 0);
        apb_write(ADDR_PM_SRC, 32'(src_raw));
        apb_write(ADDR_PM_GAIN, 0);
        apb_write(ADDR_STAT_CFG, 1 << STAT_CLEAR_BIT);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] rdata;
        int          raw;
        int          am_raw;
        int          gain;
        int          base;
        int          shift;
        int          lo;
        int          hi;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        paddr = '0;
        pwrite = 1'b0;
        pwdata = '0;
        ina = '0;
        inb = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every table entry holds its own index
        for (int i = 0; i < 2 ** TABLE_AW; i++) begin
            apb_write(ADDR_TABLE, (i << TABLE_ADDR_LSB) | (i << TABLE_DATA_LSB));
        end

        for (int i = 0; i < 16; i++) begin
            data = random_bits(32);
            // keep the table entry equal to its address
            if (RW_ADDR[i] == ADDR_TABLE) begin
                data = {16'd0, data[7:0], data[7:0]};
            end
            apb_write(RW_ADDR[i], data);
            apb_read(RW_ADDR[i], rdata);
            check_equal(rdata, data & RW_MASK[i], $sformatf("readback at 0x%0h", RW_ADDR[i]));
        end

        // a gain of four on the raw path saturates both ways
        restore_defaults();
        apb_write(ADDR_RAW, 100);
        apb_write(ADDR_AM_GAIN, 4 * UNITY);
        wait_cycles(SETTLE);
        expect_output(127);
        apb_write(ADDR_RAW, 32'(-100));
        wait_cycles(SETTLE);
        expect_output(-128);
        for (int i = 0; i < 10; i++) begin
            raw = random_signed(SAMPLE_W);
            am_raw = (i < 5) ? UNITY : random_signed(MOD_W);
            gain = random_signed(MOD_W);
            apb_write(ADDR_RAW, 32'(raw));
            apb_write(ADDR_AM_RAW, 32'(am_raw));
            apb_write(ADDR_AM_GAIN, 32'(gain));
            wait_cycles(SETTLE);
            expect_output(expected_out(raw, 0, am_raw, gain));
        end

        // external inputs
        apb_write(ADDR_AM_RAW, UNITY);
        for (int i = 0; i < 4; i++) begin
            ina = random_signed(SAMPLE_W);
            inb = random_signed(SAMPLE_W);
            gain = random_signed(10);
            apb_write(ADDR_AM_GAIN, 32'(gain));
            apb_write(ADDR_OUT_SEL, 32'(src_ina));
            wait_cycles(SETTLE);
            expect_output(expected_out(ina, 0, UNITY, gain));
            apb_write(ADDR_OUT_SEL, 32'(src_inb));
            wait_cycles(SETTLE);
            expect_output(expected_out(inb, 0, UNITY, gain));
        end

        // synthesizer
        restore_defaults();
        apb_write(ADDR_OUT_SEL, 32'(src_dds));
        apb_write(ADDR_STEP, STEP_ONE);
        wait_cycles(SETTLE);
        check_stride(20, 1, "synthesizer stride");
        // scaled FM of 256 adds one more entry per clock
        apb_write(ADDR_FM_RAW, UNITY);
        apb_write(ADDR_FM_GAIN, UNITY);
        wait_cycles(SETTLE);
        check_stride(20, 2, "synthesizer stride with FM");
        apb_write(ADDR_FM_GAIN, 0);
        apb_write(ADDR_STEP, 0);
        wait_cycles(SETTLE);
        base = dds_out;
        shift = random_bits(8);
        apb_write(ADDR_PM_RAW, 32'(shift << GAIN_RADIX));
        apb_write(ADDR_PM_GAIN, UNITY);
        wait_cycles(SETTLE);
        check_equal((dds_out - base) & 255, shift, "PM table offset");
        apb_write(ADDR_STEP, STEP_ONE);
        wait_cycles(SETTLE);
        check_stride(20, 1, "synthesizer stride with PM");

        // statistics on a constant output
        restore_defaults();
        // small enough that the noise bounds stay inside the sample range
        raw = random_signed(SAMPLE_W - 2);
        apb_write(ADDR_RAW, 32'(raw));
        apb_write(ADDR_STAT_LIMIT, 50);
        wait_cycles(SETTLE);
        apb_write(ADDR_STAT_CFG, STAT_START);
        wait_stat_count(50);
        wait_cycles(8);
        apb_read(ADDR_STAT_COUNT, rdata);
        check_equal(rdata, 50, "statistics count held at limit");
        apb_read(ADDR_STAT_MIN, rdata);
        check_equal($signed(rdata[SAMPLE_W-1:0]), expected_out(raw, 0, UNITY, UNITY),
                    "statistics minimum");
        apb_read(ADDR_STAT_MAX, rdata);
        check_equal($signed(rdata[SAMPLE_W-1:0]), expected_out(raw, 0, UNITY, UNITY),
                    "statistics maximum");

        // quarter scale noise bounds the window
        gain = UNITY / 4;
        lo = expected_out(raw, gain_clamp(-128, gain, 0, SAMPLE_W), UNITY, UNITY);
        hi = expected_out(raw, gain_clamp(127, gain, 0, SAMPLE_W), UNITY, UNITY);
        apb_write(ADDR_NOISE, gain);
        apb_write(ADDR_STAT_CFG, STAT_START);
        wait_stat_count(50);
        apb_read(ADDR_STAT_MIN, rdata);
        check_equal($signed(rdata[SAMPLE_W-1:0]) >= lo, 1, "noisy minimum above bound");
        apb_read(ADDR_STAT_MAX, rdata);
        check_equal($signed(rdata[SAMPLE_W-1:0]) <= hi, 1, "noisy maximum below bound");

        wait_cycles(4);
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 UUT.assertions_inst.failures);
        if (errors == 0 && UUT.assertions_inst.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/dds_pkg.sv
logic/dds_regs_pkg.sv
logic/gain_offset_clamp.sv
logic/prbs.sv
logic/dds.sv
logic/sigstat.sv
logic/dds_regs.sv
logic/dds_block.sv
tests/dds_block_assertions.sv
tests/dds_block_tb.sv

// ==== Bender.yml ====
package:
  name: dds_block

sources:
  - files:
      - logic/dds_pkg.sv
      - logic/dds_regs_pkg.sv
      - logic/gain_offset_clamp.sv
      - logic/prbs.sv
      - logic/dds.sv
      - logic/sigstat.sv
      - logic/dds_regs.sv
      - logic/dds_block.sv
  - target: test
    files:
      - tests/dds_block_assertions.sv
      - tests/dds_block_tb.sv
